/* src/addsub_pkg.sv */
package addsub_pkg;

    // datapath word and lookahead slice geometry
    localparam int word_width  = 32;
    localparam int slice_width = 4;
    localparam int num_slices  = word_width / slice_width;

    // status flags port
    localparam int flag_width = 4;

    // bit positions inside the flags port
    localparam int flag_carry    = 0;
    localparam int flag_overflow = 1;
    localparam int flag_zero     = 2;
    localparam int flag_negative = 3;

    // one data word, seen either whole or as one nibble per slice
    // nibble i covers bits 4i+3 down to 4i
    typedef union packed {
        logic [word_width-1:0]                   word;
        logic [num_slices-1:0][slice_width-1:0] nibble;
    } alu_word_t;

endpackage

/* src/cla_slice.sv */
`timescale 1ns/100ps

module cla_slice
    import addsub_pkg::*;
(
    input  logic [slice_width-1:0] nibble_a,
    input  logic [slice_width-1:0] nibble_b,
    input  logic                   carry_in,
    input  logic                   op_sub,
    output logic [slice_width-1:0] nibble_sum,
    output logic                   carry_out
);

    logic [slice_width-1:0] b_eff;
    logic [slice_width-1:0] gen;
    logic [slice_width-1:0] prop;
    logic [slice_width-1:0] carry;

    // ones' complement of b when subtracting, the +1 comes in on carry_in
    assign b_eff = nibble_b ^ {slice_width{op_sub}};

    // per-bit generate and propagate
    assign gen  = nibble_a & b_eff;
    assign prop = nibble_a ^ b_eff;

    // carries expanded in lookahead form, all terms from gen, prop and carry_in
    assign carry[0] = gen[0]
                    | (prop[0] & carry_in);
    assign carry[1] = gen[1]
                    | (prop[1] & gen[0])
                    | (prop[1] & prop[0] & carry_in);
    assign carry[2] = gen[2]
                    | (prop[2] & gen[1])
                    | (prop[2] & prop[1] & gen[0])
                    | (prop[2] & prop[1] & prop[0] & carry_in);
    assign carry[3] = gen[3]
                    | (prop[3] & gen[2])
                    | (prop[3] & prop[2] & gen[1])
                    | (prop[3] & prop[2] & prop[1] & gen[0])
                    | (prop[3] & prop[2] & prop[1] & prop[0] & carry_in);

    // sum bits, each takes the carry from the bit below
    assign nibble_sum[0] = prop[0] ^ carry_in;
    assign nibble_sum[1] = prop[1] ^ carry[0];
    assign nibble_sum[2] = prop[2] ^ carry[1];
    assign nibble_sum[3] = prop[3] ^ carry[2];

    // block carry into the next slice
    assign carry_out = carry[slice_width-1];

endmodule

/* src/addsub_request_port.sv */
`timescale 1ns/100ps

module addsub_request_port
    import addsub_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  logic      req,
    input  alu_word_t operand1,
    input  alu_word_t operand2,
    input  logic      operation,
    output alu_word_t a_word,
    output alu_word_t b_word,
    output logic      op_sub,
    output logic      load,
    output logic      ack
);

    // handshake FSM states
    localparam logic [1:0] st_idle    = 2'd0;
    localparam logic [1:0] st_compute = 2'd1;
    localparam logic [1:0] st_hold    = 2'd2;

    logic [1:0] state;
    logic [1:0] state_next;
    logic       capture;
    logic       release_ack;

    // a new request is only taken in idle, so never while ack is up
    assign capture = (state == st_idle) && req;

    // requester has dropped req after seeing ack
    assign release_ack = (state == st_hold) && ack && !req;

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (capture) begin
                    state_next = st_compute;
                end
            end
            st_compute: begin
                state_next = st_hold;
            end
            st_hold: begin
                if (release_ack) begin
                    state_next = st_idle;
                end
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= st_idle;
            load  <= 1'b0;
            ack   <= 1'b0;
        end else begin
            state <= state_next;

            // one-cycle strobe once the slices have settled on the captured words
            load <= (state == st_compute);

            // ack comes up on the same edge the collector takes the result
            if (load) begin
                ack <= 1'b1;
            end else if (release_ack) begin
                ack <= 1'b0;
            end
        end
    end

    // operand registers, loaded only on acceptance
    always_ff @(posedge clk) begin
        if (capture) begin
            a_word <= operand1;
            b_word <= operand2;
            op_sub <= operation;
        end
    end

endmodule

/* src/addsub_result_collector.sv */
`timescale 1ns/100ps

module addsub_result_collector
    import addsub_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  load,
    input  alu_word_t             sum_word,
    input  logic                  carry_out,
    input  logic                  op_sub,
    input  logic                  sign_a,
    input  logic                  sign_b,
    output alu_word_t             result,
    output logic [flag_width-1:0] flags
);

    logic                  sign_b_eff;
    logic                  sign_sum;
    logic [flag_width-1:0] flags_next;

    // sign of the operand the adder really sees
    assign sign_b_eff = sign_b ^ op_sub;
    assign sign_sum   = sum_word.word[word_width-1];

    always_comb begin
        flags_next = '0;

        // for subtraction a set carry means no borrow
        flags_next[flag_carry] = carry_out;

        // same-signed inputs producing a result of the other sign
        flags_next[flag_overflow] = (sign_a == sign_b_eff) && (sign_sum != sign_a);

        flags_next[flag_zero]     = (sum_word.word == '0);
        flags_next[flag_negative] = sign_sum;
    end

    // result and flags stay put between loads
    always_ff @(posedge clk) begin
        if (reset) begin
            result <= '0;
            flags  <= '0;
        end else if (load) begin
            result <= sum_word;
            flags  <= flags_next;
        end
    end

endmodule

/* src/alu_addsub_unit.sv */
`timescale 1ns/100ps

module alu_addsub_unit
    import addsub_pkg::*;
(
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  req,
    input  alu_word_t             operand1,
    input  alu_word_t             operand2,
    input  logic                  operation,
    output logic                  ack,
    output alu_word_t             result,
    output logic [flag_width-1:0] flags
);

    alu_word_t             a_word;
    alu_word_t             b_word;
    logic                  op_sub;
    logic                  load;
    wire alu_word_t        sum_word;
    wire [num_slices:0]    carry;

    addsub_request_port u_request_port (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .operand1  (operand1),
        .operand2  (operand2),
        .operation (operation),
        .a_word    (a_word),
        .b_word    (b_word),
        .op_sub    (op_sub),
        .load      (load),
        .ack       (ack)
    );

    // the subtract bit supplies the +1 of the two's complement
    assign carry[0] = op_sub;

    // block carries ripple from slice to slice
    for (genvar i = 0; i < num_slices; i++) begin : g_slice
        cla_slice u_slice (
            .nibble_a   (a_word.nibble[i]),
            .nibble_b   (b_word.nibble[i]),
            .carry_in   (carry[i]),
            .op_sub     (op_sub),
            .nibble_sum (sum_word.nibble[i]),
            .carry_out  (carry[i+1])
        );
    end

    addsub_result_collector u_result_collector (
        .clk       (clk),
        .reset     (reset),
        .load      (load),
        .sum_word  (sum_word),
        .carry_out (carry[num_slices]),
        .op_sub    (op_sub),
        .sign_a    (a_word.word[word_width-1]),
        .sign_b    (b_word.word[word_width-1]),
        .result    (result),
        .flags     (flags)
    );

endmodule

/* testbench/addsub_model.svh */
`ifndef addsub_model_svh
`define addsub_model_svh

// expected word, straight from the two's complement arithmetic
function automatic alu_word_t model_result(input alu_word_t a, input alu_word_t b, input logic sub);
    alu_word_t r;
    if (sub) begin
        r.word = a.word - b.word;
    end else begin
        r.word = a.word + b.word;
    end
    return r;
endfunction

// flags from a 33-bit sum or difference
function automatic logic [flag_width-1:0] model_flags(input alu_word_t a, input alu_word_t b,
                                                      input logic sub);
    logic [word_width:0]   wide;
    logic                  sign_a;
    logic                  sign_b;
    logic                  sign_r;
    logic [flag_width-1:0] f;
    f = '0;
    sign_a = a.word[word_width-1];
    sign_b = b.word[word_width-1];
    if (sub) begin
        wide = {1'b0, a.word} - {1'b0, b.word};
        // bit 32 set here means a borrow was needed
        f[flag_carry] = !wide[word_width];
    end else begin
        wide = {1'b0, a.word} + {1'b0, b.word};
        f[flag_carry] = wide[word_width];
    end
    sign_r = wide[word_width-1];
    if (sub) begin
        f[flag_overflow] = (sign_a != sign_b) && (sign_r != sign_a);
    end else begin
        f[flag_overflow] = (sign_a == sign_b) && (sign_r != sign_a);
    end
    f[flag_zero]     = (wide[word_width-1:0] == '0);
    f[flag_negative] = sign_r;
    return f;
endfunction

task automatic check_result(input alu_word_t got, input alu_word_t expected);
    if (got !== expected) begin
        $display("CHECK FAILED at %0t: result got %h expected %h",
                 $time, got.word, expected.word);
        abort_run();
    end
endtask

task automatic check_flags(input logic [flag_width-1:0] got, input logic [flag_width-1:0] expected);
    if (got !== expected) begin
        $display("CHECK FAILED at %0t: flags got %b expected %b (n z v c)",
                 $time, got, expected);
        abort_run();
    end
endtask

task automatic check_ack(input logic got, input logic expected);
    if (got !== expected) begin
        $display("CHECK FAILED at %0t: ack got %b expected %b", $time, got, expected);
        abort_run();
    end
endtask

task automatic check_latency(input int got, input int expected);
    if (got != expected) begin
        $display("CHECK FAILED at %0t: ack latency got %0d edges expected %0d",
                 $time, got, expected);
        abort_run();
    end
endtask

`endif

/* testbench/tb_alu_addsub_unit.sv */
`timescale 1ns/100ps

module tb_alu_addsub_unit
    import addsub_pkg::*;
();

    localparam int clk_period  = 10;
    localparam int ack_timeout = 20;
    localparam int num_add     = 300;
    localparam int num_sub     = 200;
    localparam int max_idle    = 6;

    logic                  clk;
    logic                  reset;
    logic                  req;
    alu_word_t             operand1;
    alu_word_t             operand2;
    logic                  operation;
    logic                  ack;
    alu_word_t             result;
    logic [flag_width-1:0] flags;

    integer                seed;
    alu_word_t             exp_result;
    logic [flag_width-1:0] exp_flags;

    alu_addsub_unit dut (
        .clk       (clk),
        .reset     (reset),
        .req       (req),
        .operand1  (operand1),
        .operand2  (operand2),
        .operation (operation),
        .ack       (ack),
        .result    (result),
        .flags     (flags)
    );

    `include "addsub_model.svh"

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    function automatic logic [flag_width-1:0] make_flags(input logic c, input logic v,
                                                         input logic z, input logic n);
        logic [flag_width-1:0] f;
        f = '0;
        f[flag_carry]    = c;
        f[flag_overflow] = v;
        f[flag_zero]     = z;
        f[flag_negative] = n;
        return f;
    endfunction

    // counts falling edges until ack reaches the wanted level
    task automatic wait_for_ack(input logic level, output int cycles);
        bit seen;
        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < ack_timeout) begin
            @(negedge clk);
            cycles++;
            seen = (ack === level);
        end
        if (!seen) begin
            if (level) begin
                $display("ERROR at %0t: ack did not rise within %0d cycles", $time, ack_timeout);
            end else begin
                $display("ERROR at %0t: ack did not fall within %0d cycles", $time, ack_timeout);
            end
            abort_run();
        end
    endtask

    // one full four-phase transaction, then a random idle gap
    task automatic run_transaction(input alu_word_t a, input alu_word_t b, input logic sub);
        int          cycles;
        int          idle;
        logic [31:0] rnd;
        @(posedge clk);
        req       <= 1'b1;
        operand1  <= a;
        operand2  <= b;
        operation <= sub;
        exp_result = model_result(a, b, sub);
        exp_flags  = model_flags(a, b, sub);

        // first falling edge follows the driving edge, the next one the sampling edge
        wait_for_ack(1'b1, cycles);
        check_latency(cycles - 2, 2);
        check_result(result, exp_result);
        check_flags(flags, exp_flags);

        @(posedge clk);
        req <= 1'b0;
        wait_for_ack(1'b0, cycles);

        // outputs must hold while req is low and the operand bus carries junk
        idle = {$random(seed)} % max_idle;
        repeat (idle) begin
            @(posedge clk);
            rnd            = $random(seed);
            operand1.word <= rnd;
            rnd            = $random(seed);
            operand2.word <= rnd;
            operation     <= rnd[0];
            @(negedge clk);
            check_ack(ack, 1'b0);
            check_result(result, exp_result);
            check_flags(flags, exp_flags);
        end
    endtask

    // directed case checked against the model and against a hand-worked answer
    task automatic run_directed(input logic [word_width-1:0] a_val,
                                input logic [word_width-1:0] b_val, input logic sub,
                                input logic [word_width-1:0] want,
                                input logic [flag_width-1:0] want_flags);
        alu_word_t a;
        alu_word_t b;
        alu_word_t w;
        a.word = a_val;
        b.word = b_val;
        w.word = want;
        run_transaction(a, b, sub);
        check_result(result, w);
        check_flags(flags, want_flags);
    endtask

    initial begin
        alu_word_t a;
        alu_word_t b;
        seed      = 32'ha3b1;
        reset     = 1'b1;
        req       = 1'b0;
        operand1  = '0;
        operand2  = '0;
        operation = 1'b0;

        repeat (5) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_ack(ack, 1'b0);
        check_result(result, '0);
        check_flags(flags, '0);

        for (int i = 0; i < num_add; i++) begin
            a.word = $random(seed);
            b.word = $random(seed);
            run_transaction(a, b, 1'b0);
        end

        // carry ripples through all eight slices
        run_directed(32'hffff_ffff, 32'h0000_0001, 1'b0, 32'h0000_0000,
                     make_flags(1'b1, 1'b0, 1'b1, 1'b0));

        for (int i = 0; i < num_sub; i++) begin
            a.word = $random(seed);
            b.word = $random(seed);
            if (i % 16 == 0) begin
                b = a;
            end
            run_transaction(a, b, 1'b1);
        end

        run_directed(32'h0000_04d2, 32'h0000_04d2, 1'b1, 32'h0000_0000,
                     make_flags(1'b1, 1'b0, 1'b1, 1'b0));

        // signed overflow and sign
        run_directed(32'h7fff_ffff, 32'h0000_0001, 1'b0, 32'h8000_0000,
                     make_flags(1'b0, 1'b1, 1'b0, 1'b1));
        run_directed(32'h8000_0000, 32'h0000_0001, 1'b1, 32'h7fff_ffff,
                     make_flags(1'b1, 1'b1, 1'b0, 1'b0));
        run_directed(32'h0000_0005, 32'h0000_0009, 1'b1, 32'hffff_fffc,
                     make_flags(1'b0, 1'b0, 1'b0, 1'b1));

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

/* project.f */
+incdir+testbench
src/addsub_pkg.sv
src/cla_slice.sv
src/addsub_request_port.sv
src/addsub_result_collector.sv
src/alu_addsub_unit.sv
testbench/tb_alu_addsub_unit.sv

/* Bender.yml */
package:
  name: alu_addsub_unit

sources:
  - src/addsub_pkg.sv
  - src/cla_slice.sv
  - src/addsub_request_port.sv
  - src/addsub_result_collector.sv
  - src/alu_addsub_unit.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_alu_addsub_unit.sv
